// ==== music_pkg.sv ====
package music_pkg;

    // ------------------------------
    // Widths that carry a meaning
    // ------------------------------

    typedef logic [5:0] note_t;     // Note number, 64 pitches.
    typedef logic [5:0] beats_t;    // Length of a note or a rest, counted in beats.
    typedef logic [1:0] song_sel_t; // One of the four songs held in the ROM.

    // Number of note players that can sound at the same time.
    localparam int unsigned NUM_VOICES = 3;

    // ------------------------------
    // Structures
    // ------------------------------

    // One ROM entry. With is_wait low it is a note and both fields are used.
    // With is_wait high the note field is ignored and duration is a rest in beats.
    // A rest of zero beats marks the end of the song.
    typedef struct packed {
        logic   is_wait;  // High for a rest or the end marker.
        note_t  note;     // Note number, only meaningful for a note entry.
        beats_t duration; // Beats to hold the note or to rest.
    } rom_entry_t;

    // What the reader hands to a voice when a note is transferred.
    typedef struct packed {
        note_t  note;
        beats_t duration;
    } note_cmd_t;

    // The visible state of one voice.
    typedef struct packed {
        logic  active; // High while the voice is sounding.
        note_t note;   // The note being sounded, zero when silent.
    } voice_t;

endpackage

// ==== beat_generator.sv ====
`timescale 1ns/10ps

module beat_generator #(
    parameter int unsigned BEAT_DIVIDE = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic play,
    output logic beat
);

    localparam int unsigned CNT_W = (BEAT_DIVIDE > 1) ? $clog2(BEAT_DIVIDE) : 1;

    logic [CNT_W-1:0] count_q; // Cycles elapsed inside the current beat.
    logic             beat_q;  // Registered wrap pulse.

    always_ff @(posedge clk) begin
        if (rst || !play) begin
            count_q <= '0; // Paused, so the next beat after resume is a whole one.
            beat_q  <= 1'b0;
        end else if (count_q == CNT_W'(BEAT_DIVIDE - 1)) begin
            count_q <= '0;
            beat_q  <= 1'b1; // Wraparound gives the beat in the following cycle.
        end else begin
            count_q <= count_q + 1'b1;
            beat_q  <= 1'b0;
        end
    end

    // A pulse that was already registered is dropped in the cycle where play falls.
    assign beat = beat_q && play;

    // Beats are isolated single-cycle strobes, downstream counters rely on it.
    a_beat_single_cycle: assert property (@(posedge clk) disable iff (rst) beat |=> !beat)
        else $error("beat held high for two cycles");

endmodule

// ==== song_rom.sv ====
`timescale 1ns/10ps

module song_rom #(
    parameter int unsigned SONG_ADDR_WIDTH = 5
) (
    input  logic                         clk,
    input  logic [SONG_ADDR_WIDTH+1:0]   addr,
    output music_pkg::rom_entry_t        entry
);

    music_pkg::song_sel_t       song_sel; // Upper address bits pick the song.
    logic [SONG_ADDR_WIDTH-1:0] index;    // Lower bits pick the entry inside it.

    assign song_sel = addr[SONG_ADDR_WIDTH+1:SONG_ADDR_WIDTH];
    assign index    = addr[SONG_ADDR_WIDTH-1:0];

    // Entry builders keep the table below readable.
    function automatic music_pkg::rom_entry_t note(input int unsigned n, input int unsigned d);
        return '{is_wait: 1'b0, note: music_pkg::note_t'(n), duration: music_pkg::beats_t'(d)};
    endfunction

    function automatic music_pkg::rom_entry_t rest(input int unsigned d);
        return '{is_wait: 1'b1, note: '0, duration: music_pkg::beats_t'(d)};
    endfunction

    // ------------------------------
    // Song table
    // ------------------------------

    always_ff @(posedge clk) begin
        entry <= rest(0); // Anything not listed reads as an end marker.
        case (song_sel)
            2'd0: begin // A plain melody, every note ends before the next one starts.
                case (index)
                    0:  entry <= note(24, 2);
                    1:  entry <= rest(2);
                    2:  entry <= note(26, 2);
                    3:  entry <= rest(2);
                    4:  entry <= note(28, 3);
                    5:  entry <= rest(3);
                    6:  entry <= note(24, 1);
                    7:  entry <= rest(1);
                    8:  entry <= note(31, 4);
                    9:  entry <= rest(4);
                    default: entry <= rest(0);
                endcase
            end
            2'd1: begin // Chords, two or three voices sound together.
                case (index)
                    0:  entry <= note(36, 4);
                    1:  entry <= note(40, 4);
                    2:  entry <= rest(2);
                    3:  entry <= note(43, 4);
                    4:  entry <= rest(4);
                    5:  entry <= note(48, 2);
                    6:  entry <= note(52, 2);
                    7:  entry <= rest(3);
                    default: entry <= rest(0);
                endcase
            end
            2'd2: begin // Four notes in a row, the fourth has to wait for a free voice.
                case (index)
                    0:  entry <= note(12, 3);
                    1:  entry <= note(14, 3);
                    2:  entry <= note(16, 3);
                    3:  entry <= note(19, 2);
                    4:  entry <= rest(3);
                    default: entry <= rest(0);
                endcase
            end
            default: entry <= rest(0); // Song 3 ends at once.
        endcase
    end

endmodule

// ==== wait_timer.sv ====
`timescale 1ns/10ps

module wait_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  music_pkg::beats_t duration,
    input  logic              beat,
    output logic              expired
);

    music_pkg::beats_t count_q; // Beats of rest still to go.

    // ------------------------------
    // Countdown
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0; // Idle timer reads as expired.
        end else if (load) begin
            count_q <= duration; // A beat in the load cycle is not counted.
        end else if (beat && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Goes high in the cycle after the last beat of the rest.
    assign expired = (count_q == '0);

    // A zero rest is the end marker and must never reach the timer.
    a_no_zero_load: assert property (@(posedge clk) disable iff (rst)
        load |-> (duration != '0))
        else $error("wait timer loaded with a zero duration");

endmodule

// ==== voice_arbiter.sv ====
`timescale 1ns/10ps

module voice_arbiter (
    input  logic                                note_req,
    input  logic [music_pkg::NUM_VOICES-1:0]    busy,
    output logic [music_pkg::NUM_VOICES-1:0]    start,
    output logic                                note_accept
);

    logic [music_pkg::NUM_VOICES-1:0] free;   // Voices that can take a note now.
    logic [music_pkg::NUM_VOICES-1:0] lowest; // Only the lowest free voice.

    assign free = ~busy;

    // Two's complement isolates the lowest set bit, so voice 0 has top priority.
    assign lowest = free & (~free + 1'b1);

    // No request, no start.
    assign start = note_req ? lowest : '0;

    // The reader sees the transfer in the same cycle the voice gets its start.
    assign note_accept = |start;

    // At most one voice is started, and never one that is still sounding.
    always_comb begin
        a_start_onehot: assert final ($onehot0(start) && ((start & busy) == '0))
            else $error("arbiter start %b is not one-hot on a free voice", start);
    end

endmodule

// ==== note_player.sv ====
`timescale 1ns/10ps

module note_player (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  music_pkg::note_cmd_t cmd,
    input  logic                 beat,
    output logic                 busy,
    output music_pkg::voice_t    voice
);

    logic              active_q; // Voice is sounding.
    music_pkg::note_t  note_q;   // Note captured at start.
    music_pkg::beats_t count_q;  // Beats left before release.

    // ------------------------------
    // Hold and release
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            count_q  <= '0;
        end else if (start) begin
            active_q <= 1'b1;         // Sounding from the next cycle on.
            count_q  <= cmd.duration; // A beat in the start cycle is not counted.
        end else if (active_q && beat) begin
            if (count_q <= 1) begin
                active_q <= 1'b0; // Last beat, silent from the next cycle.
                count_q  <= '0;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Note number is only captured, it has no meaning until start.
    always_ff @(posedge clk) begin
        if (start) begin
            note_q <= cmd.note;
        end
    end

    assign busy = active_q;

    // A silent voice reports note zero.
    assign voice = '{active: active_q, note: active_q ? note_q : '0};

    // The arbiter must only start a voice that has finished its last note.
    a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("note player started while busy");

endmodule

// ==== song_reader_fsm.sv ====
`timescale 1ns/10ps

module song_reader_fsm #(
    parameter int unsigned SONG_ADDR_WIDTH = 5
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        play,
    input  music_pkg::song_sel_t        song,
    input  music_pkg::rom_entry_t       entry,
    input  logic                        expired,
    input  logic                        note_accept,
    output logic [SONG_ADDR_WIDTH+1:0]  addr,
    output logic                        note_req,
    output music_pkg::note_cmd_t        cmd,
    output logic                        timer_load,
    output music_pkg::beats_t           wait_beats,
    output logic                        song_done
);

    typedef enum logic [2:0] {
        PAUSED,   // Idle, song number is sampled here.
        FETCH,    // Address is presented to the ROM.
        RETRIEVE, // Entry is valid and gets decoded.
        WAIT,     // A rest is counting down.
        DONE      // End marker reached.
    } state_t;

    state_t                     state_q, state_d;
    logic [SONG_ADDR_WIDTH-1:0] index_q, index_d; // Entry inside the current song.
    music_pkg::song_sel_t       song_q;           // Song latched while paused.
    logic                       is_end;           // Current entry is the end marker.

    assign is_end = entry.is_wait && (entry.duration == '0);

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        state_d    = state_q;
        index_d    = index_q;
        note_req   = 1'b0;
        timer_load = 1'b0;
        if (!play) begin
            state_d = PAUSED; // Position is kept so the song can resume.
            if (state_q == DONE) begin
                index_d = '0; // A finished song restarts from the top.
            end
        end else begin
            case (state_q)
                PAUSED:   state_d = FETCH;
                FETCH:    state_d = RETRIEVE;
                RETRIEVE: begin
                    // Expired is low only when a pause cut a rest short.
                    // The remainder of that rest is served before moving on.
                    if (expired) begin
                        if (!entry.is_wait) begin
                            note_req = 1'b1; // Held until a voice is free.
                            if (note_accept) begin
                                index_d = index_q + 1'b1;
                                state_d = FETCH;
                            end
                        end else if (is_end) begin
                            state_d = DONE;
                        end else begin
                            timer_load = 1'b1;
                            index_d    = index_q + 1'b1;
                            state_d    = WAIT;
                        end
                    end
                end
                WAIT:     if (expired) state_d = FETCH;
                DONE:     state_d = DONE; // Stays until play drops.
                default:  state_d = PAUSED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= PAUSED;
            index_q <= '0;
            song_q  <= '0;
        end else begin
            state_q <= state_d;
            index_q <= index_d;
            if (state_q == PAUSED) begin
                song_q <= song; // A song change takes effect only from a pause.
            end
        end
    end

    assign addr       = {song_q, index_q};
    assign cmd        = '{note: entry.note, duration: entry.duration};
    assign wait_beats = entry.duration;
    assign song_done  = (state_q == DONE);

endmodule

// ==== music_top.sv ====
`timescale 1ns/10ps

module music_top #(
    parameter int unsigned BEAT_DIVIDE     = 8,
    parameter int unsigned SONG_ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  play,
    input  music_pkg::song_sel_t  song,
    output music_pkg::voice_t     voices [music_pkg::NUM_VOICES],
    output logic                  beat,
    output logic                  song_done
);

    logic [SONG_ADDR_WIDTH+1:0]       rom_addr;    // {song, index} from the reader.
    music_pkg::rom_entry_t            rom_entry;   // Entry one cycle after the address.
    logic                             note_req;    // Reader has a note to place.
    logic                             note_accept; // Some voice took it.
    music_pkg::note_cmd_t             note_cmd;    // Broadcast to every voice.
    logic                             timer_load;
    music_pkg::beats_t                wait_beats;
    logic                             expired;
    logic [music_pkg::NUM_VOICES-1:0] busy;
    logic [music_pkg::NUM_VOICES-1:0] start;

    // ------------------------------
    // Timing and sequencing
    // ------------------------------

    beat_generator #(.BEAT_DIVIDE(BEAT_DIVIDE)) beat_gen_i (
        .clk(clk), .rst(rst), .play(play), .beat(beat)
    );

    song_rom #(.SONG_ADDR_WIDTH(SONG_ADDR_WIDTH)) rom_i (
        .clk(clk), .addr(rom_addr), .entry(rom_entry)
    );

    song_reader_fsm #(.SONG_ADDR_WIDTH(SONG_ADDR_WIDTH)) reader_i (
        .clk(clk), .rst(rst), .play(play), .song(song), .entry(rom_entry),
        .expired(expired), .note_accept(note_accept), .addr(rom_addr),
        .note_req(note_req), .cmd(note_cmd), .timer_load(timer_load),
        .wait_beats(wait_beats), .song_done(song_done)
    );

    wait_timer timer_i (
        .clk(clk), .rst(rst), .load(timer_load), .duration(wait_beats),
        .beat(beat), .expired(expired)
    );

    // ------------------------------
    // Voices
    // ------------------------------

    voice_arbiter arbiter_i (
        .note_req(note_req), .busy(busy), .start(start), .note_accept(note_accept)
    );

    for (genvar v = 0; v < music_pkg::NUM_VOICES; v++) begin : g_voice
        note_player player_i (
            .clk(clk), .rst(rst), .start(start[v]), .cmd(note_cmd),
            .beat(beat), .busy(busy[v]), .voice(voices[v])
        );
    end

endmodule

// ==== tb_music_checker.sv ====
`timescale 1ns/10ps

module tb_music_checker (
    input logic              clk,
    input logic              rst,
    input logic              play,
    input music_pkg::voice_t voices [music_pkg::NUM_VOICES],
    input logic              beat,
    input logic              song_done
);

    localparam int NV = music_pkg::NUM_VOICES;

    // ------------------------------
    // Expected note events
    // ------------------------------

    // Note entries of all four songs in ROM order.
    // Columns are note number, beats held and the rest in beats just before the note.
    localparam int EXP_NOTE [14] = '{24, 26, 28, 24, 31, 36, 40, 43, 48, 52, 12, 14, 16, 19};
    localparam int EXP_DUR  [14] = '{2, 2, 3, 1, 4, 4, 4, 4, 2, 2, 3, 3, 3, 2};
    localparam int EXP_GAP  [14] = '{0, 2, 2, 3, 1, 0, 0, 2, 4, 0, 0, 0, 0, 0};
    localparam int SONG_FIRST [4] = '{0, 5, 10, 14}; // First row of each song.
    localparam int SONG_COUNT [4] = '{5, 5, 4, 0};   // Song 3 holds no notes.

    string            test_name = "idle";
    int               first_idx = 0;   // Table row of the first note of the song.
    int               song_notes = 0;  // Notes the table holds for this song.
    int               row_notes = 0;   // Notes the stimulus row expects.
    int               next_note = 0;   // Notes started so far in this test.
    int               error_count = 0;
    int               gap_beats = 0;   // Beats seen since the last note started.
    int               held_beats [NV] = '{default: 0};
    int               held_dur [NV] = '{default: 0};
    logic [NV-1:0]    prev_active = '0;
    logic             prev_play = 1'b0;
    logic             prev_done = 1'b0;
    logic             prev_rst = 1'b1;

    task automatic fail_value(input string what, input int expected, input int actual);
        error_count++;
        $display("FAILED %s %s: expected %0d, actual %0d (t=%0t)",
                 test_name, what, expected, actual, $time);
    endtask

    task automatic fail_text(input string msg);
        error_count++;
        $display("ERROR in %s at %0t: %s", test_name, $time, msg);
    endtask

    // Called by the testbench just before play rises for a new test.
    task automatic start_test(input string name, input int song, input int notes);
        test_name  = name;
        first_idx  = SONG_FIRST[song];
        song_notes = SONG_COUNT[song];
        row_notes  = notes;
        next_note  = 0;
    endtask

    task automatic finish_test();
        if (next_note != row_notes) begin
            fail_value("notes started", row_notes, next_note);
        end
    endtask

    // ------------------------------
    // Watcher
    // ------------------------------

    // Sampling at the falling edge sees every output settled.
    always @(negedge clk) begin : watch
        int rises;
        int free_v;
        int idx;
        rises  = 0;
        free_v = -1; // Lowest voice that was silent in the transfer cycle.
        for (int v = NV - 1; v >= 0; v--) begin
            if (!prev_active[v]) free_v = v;
        end
        if (rst || prev_rst) begin
            for (int v = 0; v < NV; v++) begin
                if (voices[v].active !== 1'b0) fail_text("a voice is active in reset");
            end
            if (song_done !== 1'b0) fail_text("song_done is not low in reset");
            if (beat !== 1'b0) fail_text("beat is not low in reset");
        end else begin
            if (!play && beat) fail_text("beat pulsed while play was low");
            if (song_done && !prev_done && next_note != song_notes) begin
                fail_value("notes before song_done", song_notes, next_note);
            end
            if (prev_done && !song_done && prev_play) fail_text("song_done fell while playing");
            if (song_done && !prev_play) fail_text("song_done stayed high after play dropped");
            for (int v = 0; v < NV; v++) begin
                if (voices[v].active && !prev_active[v]) begin
                    rises++;
                    if (!prev_play) fail_text("a voice started while play was low");
                    if (free_v < 0) begin
                        fail_text("a voice started while all voices were busy");
                    end else if (v != free_v) begin
                        fail_value("voice chosen", free_v, v);
                    end
                    if (next_note >= song_notes) begin
                        fail_text("a note started after the last note of the song");
                        held_dur[v] = 0;
                    end else begin
                        idx = first_idx + next_note;
                        if (voices[v].note != EXP_NOTE[idx]) begin
                            fail_value("note", EXP_NOTE[idx], voices[v].note);
                        end
                        if (gap_beats < EXP_GAP[idx]) begin
                            fail_value("rest beats before note", EXP_GAP[idx], gap_beats);
                        end
                        held_dur[v] = EXP_DUR[idx];
                    end
                    held_beats[v] = 0;
                    next_note++;
                end
                // A released voice must have heard exactly its own beats.
                if (!voices[v].active && prev_active[v] && held_beats[v] != held_dur[v]) begin
                    fail_value("beats held", held_dur[v], held_beats[v]);
                end
                if (voices[v].active && beat) held_beats[v]++; // Player counts this beat next.
            end
            if (rises > 1) fail_value("voices started in one cycle", 1, rises);
            gap_beats = (rises != 0) ? int'(beat) : gap_beats + int'(beat);
        end
        for (int v = 0; v < NV; v++) begin
            prev_active[v] = voices[v].active;
        end
        prev_play = play;
        prev_done = song_done;
        prev_rst  = rst;
    end

endmodule

// ==== tb_music_top.sv ====
`timescale 1ns/10ps

module tb_music_top;

    localparam int BEAT_DIVIDE  = 4;
    localparam int DONE_TIMEOUT = 400; // Cycles allowed for one song to finish.
    localparam int HOLD_CYCLES  = 6;   // Play stays high this long after song_done.
    localparam int PAUSE_CYCLES = 12;  // Length of a mid-song pause.

    // One test per row.
    typedef struct {
        string name;     // Shown in every error line.
        int    song;     // Song number driven on the song input.
        int    pause_at; // Cycles after play rises to drop it, -1 for no pause.
        int    notes;    // Note events expected before song_done.
    } test_row_t;

    logic                 clk;
    logic                 rst;
    logic                 play;
    music_pkg::song_sel_t song;
    music_pkg::voice_t    voices [music_pkg::NUM_VOICES];
    logic                 beat;
    logic                 song_done;
    int                   timeouts = 0;

    // ------------------------------
    // Stimulus table
    // ------------------------------

    test_row_t tests [5] = '{
        '{"song0_melody", 0, -1, 5},
        '{"song1_chords", 1, -1, 5},
        '{"song2_stall",  2, -1, 4},
        '{"song3_empty",  3, -1, 0},
        '{"song1_pause",  1, 20, 5}  // Drops play in the middle of a rest.
    };

    music_top #(
        .BEAT_DIVIDE(BEAT_DIVIDE),
        .SONG_ADDR_WIDTH(5)
    ) dut_i (
        .clk(clk), .rst(rst), .play(play), .song(song),
        .voices(voices), .beat(beat), .song_done(song_done)
    );

    tb_music_checker checker_i (
        .clk(clk), .rst(rst), .play(play), .voices(voices),
        .beat(beat), .song_done(song_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    // Inputs change 2 ns after the rising edge, away from the sampling edge.
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_song_done(input string name);
        int cycles;
        cycles = 0;
        while (song_done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (song_done !== 1'b1) begin
            timeouts++;
            $display("ERROR in %s: song_done did not rise within %0d cycles", name, DONE_TIMEOUT);
        end
    endtask

    task automatic run_test(input test_row_t row);
        checker_i.start_test(row.name, row.song, row.notes);
        song = music_pkg::song_sel_t'(row.song);
        play = 1'b1;
        if (row.pause_at >= 0) begin
            repeat (row.pause_at) next_cycle();
            play = 1'b0; // The checker watches that nothing moves meanwhile.
            repeat (PAUSE_CYCLES) next_cycle();
            play = 1'b1;
        end
        wait_song_done(row.name);
        repeat (HOLD_CYCLES) next_cycle(); // song_done must hold while play is high.
        play = 1'b0;
        repeat (HOLD_CYCLES) next_cycle();
        checker_i.finish_test();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        rst  = 1'b1;
        play = 1'b0;
        song = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (2) next_cycle();
        foreach (tests[t]) begin
            run_test(tests[t]);
        end
        next_cycle();
        $display("Checker errors: %0d, timeouts: %0d", checker_i.error_count, timeouts);
        if (checker_i.error_count == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
music_pkg.sv
beat_generator.sv
song_rom.sv
wait_timer.sv
voice_arbiter.sv
note_player.sv
song_reader_fsm.sv
music_top.sv
tb_music_checker.sv
tb_music_top.sv

// ==== Bender.yml ====
package:
  name: music_sequencer

sources:
  - files:
      - music_pkg.sv
      - beat_generator.sv
      - song_rom.sv
      - wait_timer.sv
      - voice_arbiter.sv
      - note_player.sv
      - song_reader_fsm.sv
      - music_top.sv
  - target: test
    files:
      - tb_music_checker.sv
      - tb_music_top.sv
